// File: rob_cfg_pkg.sv
// sizes of the reorder buffer
// widths of the fields held in each entry
`default_nettype none

package rob_cfg_pkg;

	localparam int thread_depth = 16;	// entries per thread
	localparam int slot_bits = 4;		// slot index inside one thread
	localparam int pc_bits = 64;		// pc and branch target width
	localparam int arn_bits = 5;		// architectural register number
	localparam int prn_bits = 6;		// 64 physical registers
	localparam int count_bits = 5;		// occupancy, 0 to 16

endpackage

`default_nettype wire

// File: rob_types_pkg.sv
// thread identifier type
// reorder buffer tag, readable as a flat entry number or as thread plus slot
`default_nettype none

package rob_types_pkg;

	// 0 is thread 1, 1 is thread 2
	typedef logic thread_id_t;

	typedef struct packed
	{
		thread_id_t thread;								// upper bit picks the queue
		logic [rob_cfg_pkg::slot_bits-1:0] slot;		// position inside that queue
	} tag_split_t;

	// reservation stations see one flat number, the buffer splits it
	typedef union packed
	{
		logic [rob_cfg_pkg::slot_bits:0] flat;
		tag_split_t split;
	} rob_tag_t;

endpackage

`default_nettype wire

// File: rob_thread_queue.sv
// circular entry store for one thread of the reorder buffer
// head, tail and occupancy tracking, completion decode and flush
`timescale 1ns/1ps
`default_nettype none

module rob_thread_queue #(
	parameter rob_types_pkg::thread_id_t owner = 1'b0
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic [1:0] alloc_count,
	input wire logic [rob_cfg_pkg::pc_bits-1:0] inst1_pc,
	input wire logic [rob_cfg_pkg::arn_bits-1:0] inst1_arn,
	input wire logic [rob_cfg_pkg::prn_bits-1:0] inst1_prn,
	input wire logic inst1_is_branch,
	input wire logic [rob_cfg_pkg::pc_bits-1:0] inst2_pc,
	input wire logic [rob_cfg_pkg::arn_bits-1:0] inst2_arn,
	input wire logic [rob_cfg_pkg::prn_bits-1:0] inst2_prn,
	input wire logic inst2_is_branch,
	input wire logic done1_valid,
	input wire rob_types_pkg::rob_tag_t done1_tag,
	input wire logic done1_mispredict,
	input wire logic [rob_cfg_pkg::pc_bits-1:0] done1_target_pc,
	input wire logic done2_valid,
	input wire rob_types_pkg::rob_tag_t done2_tag,
	input wire logic done2_mispredict,
	input wire logic [rob_cfg_pkg::pc_bits-1:0] done2_target_pc,
	input wire logic [1:0] pop_count,
	input wire logic flush,
	output logic [rob_cfg_pkg::slot_bits-1:0] tail_slot,
	output logic [rob_cfg_pkg::count_bits-1:0] free_count,
	output logic head_ready,
	output logic [rob_cfg_pkg::pc_bits-1:0] head_pc,
	output logic [rob_cfg_pkg::pc_bits-1:0] head_target_pc,
	output logic head_is_branch,
	output logic head_mispredict,
	output logic [rob_cfg_pkg::arn_bits-1:0] head_arn,
	output logic [rob_cfg_pkg::prn_bits-1:0] head_prn,
	output logic next_ready,
	output logic [rob_cfg_pkg::pc_bits-1:0] next_pc,
	output logic [rob_cfg_pkg::pc_bits-1:0] next_target_pc,
	output logic next_is_branch,
	output logic next_mispredict,
	output logic [rob_cfg_pkg::arn_bits-1:0] next_arn,
	output logic [rob_cfg_pkg::prn_bits-1:0] next_prn
);

	localparam int depth = rob_cfg_pkg::thread_depth;

	logic [rob_cfg_pkg::pc_bits-1:0] pc_mem [depth];
	logic [rob_cfg_pkg::pc_bits-1:0] target_mem [depth];
	logic [rob_cfg_pkg::arn_bits-1:0] arn_mem [depth];
	logic [rob_cfg_pkg::prn_bits-1:0] prn_mem [depth];
	logic [depth-1:0] branch_mem;
	logic [depth-1:0] mispredict_mem;
	logic [depth-1:0] occupied;
	logic [depth-1:0] executed;

	logic [rob_cfg_pkg::slot_bits-1:0] head;
	logic [rob_cfg_pkg::slot_bits-1:0] tail;
	logic [rob_cfg_pkg::count_bits-1:0] count;
	logic [rob_cfg_pkg::slot_bits-1:0] head_next;
	logic [rob_cfg_pkg::slot_bits-1:0] tail_next;
	logic [rob_cfg_pkg::slot_bits-1:0] head_after_pop;
	logic done1_hit;
	logic done2_hit;

	assign head_next = head + 1'b1;
	assign tail_next = tail + 1'b1;
	assign head_after_pop = head + rob_cfg_pkg::slot_bits'(pop_count);

	// completions aimed at the other thread are ignored here
	assign done1_hit = done1_valid && (done1_tag.split.thread == owner);
	assign done2_hit = done2_valid && (done2_tag.split.thread == owner);

	// entry payload, written at allocation and at completion
	always_ff @(posedge clock)
	begin
		if (alloc_count != 2'd0)
		begin
			pc_mem[tail] <= inst1_pc;
			arn_mem[tail] <= inst1_arn;
			prn_mem[tail] <= inst1_prn;
			branch_mem[tail] <= inst1_is_branch;
			executed[tail] <= 1'b0;
		end
		if (alloc_count == 2'd2)
		begin
			pc_mem[tail_next] <= inst2_pc;
			arn_mem[tail_next] <= inst2_arn;
			prn_mem[tail_next] <= inst2_prn;
			branch_mem[tail_next] <= inst2_is_branch;
			executed[tail_next] <= 1'b0;
		end
		if (done1_hit)
		begin
			executed[done1_tag.split.slot] <= 1'b1;
			mispredict_mem[done1_tag.split.slot] <= done1_mispredict;
			target_mem[done1_tag.split.slot] <= done1_target_pc;
		end
		if (done2_hit)
		begin
			executed[done2_tag.split.slot] <= 1'b1;
			mispredict_mem[done2_tag.split.slot] <= done2_mispredict;
			target_mem[done2_tag.split.slot] <= done2_target_pc;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
			occupied <= '0;
		end
		else
		begin
			head <= head_after_pop;
			if (pop_count != 2'd0)
				occupied[head] <= 1'b0;
			if (pop_count == 2'd2)
				occupied[head_next] <= 1'b0;
			if (alloc_count != 2'd0)
				occupied[tail] <= 1'b1;
			if (alloc_count == 2'd2)
				occupied[tail_next] <= 1'b1;
			if (flush)
			begin
				// drop everything younger than the committed branch
				tail <= head_after_pop;
				count <= '0;
				occupied <= '0;
			end
			else
			begin
				tail <= tail + rob_cfg_pkg::slot_bits'(alloc_count);
				count <= count + rob_cfg_pkg::count_bits'(alloc_count)
					- rob_cfg_pkg::count_bits'(pop_count);
			end
		end
	end

	assign tail_slot = tail;
	assign free_count = rob_cfg_pkg::count_bits'(depth) - count;

	// oldest two entries for the commit selector
	assign head_ready = occupied[head] & executed[head];
	assign head_pc = pc_mem[head];
	assign head_target_pc = target_mem[head];
	assign head_is_branch = branch_mem[head];
	assign head_mispredict = mispredict_mem[head];
	assign head_arn = arn_mem[head];
	assign head_prn = prn_mem[head];

	assign next_ready = occupied[head_next] & executed[head_next];
	assign next_pc = pc_mem[head_next];
	assign next_target_pc = target_mem[head_next];
	assign next_is_branch = branch_mem[head_next];
	assign next_mispredict = mispredict_mem[head_next];
	assign next_arn = arn_mem[head_next];
	assign next_prn = prn_mem[head_next];

endmodule

`default_nettype wire

// File: rob_dispatch_steer.sv
// dispatch routing to the thread queues
// room check, flush blocking, tag forming and full flags
`timescale 1ns/1ps
`default_nettype none

module rob_dispatch_steer (
	input wire logic inst1_valid,
	input wire logic inst2_valid,
	input wire rob_types_pkg::thread_id_t dispatch_thread,
	input wire logic [rob_cfg_pkg::slot_bits-1:0] t1_tail_slot,
	input wire logic [rob_cfg_pkg::slot_bits-1:0] t2_tail_slot,
	input wire logic [rob_cfg_pkg::count_bits-1:0] t1_free_count,
	input wire logic [rob_cfg_pkg::count_bits-1:0] t2_free_count,
	input wire logic t1_flush,
	input wire logic t2_flush,
	output logic dispatch_accept,
	output rob_types_pkg::rob_tag_t inst1_tag,
	output rob_types_pkg::rob_tag_t inst2_tag,
	output logic [1:0] t1_alloc_count,
	output logic [1:0] t2_alloc_count,
	output logic t1_full,
	output logic t2_full
);

	logic [1:0] offered;
	logic [rob_cfg_pkg::slot_bits-1:0] tail;
	logic [rob_cfg_pkg::count_bits-1:0] free;
	logic [1:0] granted;

	// a second instruction alone does not count
	assign offered = inst1_valid ? (inst2_valid ? 2'd2 : 2'd1) : 2'd0;

	assign tail = (dispatch_thread == 1'b0) ? t1_tail_slot : t2_tail_slot;
	assign free = (dispatch_thread == 1'b0) ? t1_free_count : t2_free_count;

	// no dispatch while any thread is being flushed
	assign dispatch_accept = (free >= rob_cfg_pkg::count_bits'(offered))
		&& !(t1_flush || t2_flush);
	assign granted = dispatch_accept ? offered : 2'd0;

	assign t1_alloc_count = (dispatch_thread == 1'b0) ? granted : 2'd0;
	assign t2_alloc_count = (dispatch_thread == 1'b1) ? granted : 2'd0;

	always_comb
	begin
		inst1_tag.split.thread = dispatch_thread;
		inst1_tag.split.slot = tail;
		inst2_tag.split.thread = dispatch_thread;
		inst2_tag.split.slot = tail + 1'b1;	// wraps past slot 15
	end

	// full means a pair would not fit
	assign t1_full = t1_free_count < 2;
	assign t2_full = t2_free_count < 2;

endmodule

`default_nettype wire

// File: rob_commit_select.sv
// commit selection across both thread queues
// fills two commit slots, thread 1 first, and raises pops and flushes
`timescale 1ns/1ps
`default_nettype none

module rob_commit_select (
	input wire logic t1_head_ready,
	input wire logic [rob_cfg_pkg::pc_bits-1:0] t1_head_pc,
	input wire logic [rob_cfg_pkg::pc_bits-1:0] t1_head_target_pc,
	input wire logic t1_head_is_branch,
	input wire logic t1_head_mispredict,
	input wire logic [rob_cfg_pkg::arn_bits-1:0] t1_head_arn,
	input wire logic [rob_cfg_pkg::prn_bits-1:0] t1_head_prn,
	input wire logic t1_next_ready,
	input wire logic [rob_cfg_pkg::pc_bits-1:0] t1_next_pc,
	input wire logic [rob_cfg_pkg::pc_bits-1:0] t1_next_target_pc,
	input wire logic t1_next_is_branch,
	input wire logic t1_next_mispredict,
	input wire logic [rob_cfg_pkg::arn_bits-1:0] t1_next_arn,
	input wire logic [rob_cfg_pkg::prn_bits-1:0] t1_next_prn,
	input wire logic t2_head_ready,
	input wire logic [rob_cfg_pkg::pc_bits-1:0] t2_head_pc,
	input wire logic [rob_cfg_pkg::pc_bits-1:0] t2_head_target_pc,
	input wire logic t2_head_is_branch,
	input wire logic t2_head_mispredict,
	input wire logic [rob_cfg_pkg::arn_bits-1:0] t2_head_arn,
	input wire logic [rob_cfg_pkg::prn_bits-1:0] t2_head_prn,
	input wire logic t2_next_ready,
	input wire logic [rob_cfg_pkg::pc_bits-1:0] t2_next_pc,
	input wire logic [rob_cfg_pkg::pc_bits-1:0] t2_next_target_pc,
	input wire logic t2_next_is_branch,
	input wire logic t2_next_mispredict,
	input wire logic [rob_cfg_pkg::arn_bits-1:0] t2_next_arn,
	input wire logic [rob_cfg_pkg::prn_bits-1:0] t2_next_prn,
	output logic commit1_valid,
	output rob_types_pkg::thread_id_t commit1_thread,
	output logic [rob_cfg_pkg::pc_bits-1:0] commit1_pc,
	output logic [rob_cfg_pkg::pc_bits-1:0] commit1_target_pc,
	output logic commit1_is_branch,
	output logic commit1_mispredict,
	output logic [rob_cfg_pkg::arn_bits-1:0] commit1_arn,
	output logic [rob_cfg_pkg::prn_bits-1:0] commit1_prn,
	output logic commit2_valid,
	output rob_types_pkg::thread_id_t commit2_thread,
	output logic [rob_cfg_pkg::pc_bits-1:0] commit2_pc,
	output logic [rob_cfg_pkg::pc_bits-1:0] commit2_target_pc,
	output logic commit2_is_branch,
	output logic commit2_mispredict,
	output logic [rob_cfg_pkg::arn_bits-1:0] commit2_arn,
	output logic [rob_cfg_pkg::prn_bits-1:0] commit2_prn,
	output logic [1:0] t1_pop_count,
	output logic [1:0] t2_pop_count,
	output logic t1_flush,
	output logic t2_flush
);

	// a mispredicted branch ends its thread's commit group
	logic t1_head_bad;
	logic t1_next_bad;
	logic t2_head_bad;
	logic t2_next_bad;

	assign t1_head_bad = t1_head_is_branch & t1_head_mispredict;
	assign t1_next_bad = t1_next_is_branch & t1_next_mispredict;
	assign t2_head_bad = t2_head_is_branch & t2_head_mispredict;
	assign t2_next_bad = t2_next_is_branch & t2_next_mispredict;

	always_comb
	begin
		{commit1_valid, commit1_thread, commit1_pc, commit1_target_pc} = '0;
		{commit1_is_branch, commit1_mispredict, commit1_arn, commit1_prn} = '0;
		{commit2_valid, commit2_thread, commit2_pc, commit2_target_pc} = '0;
		{commit2_is_branch, commit2_mispredict, commit2_arn, commit2_prn} = '0;
		t1_pop_count = 2'd0;
		t2_pop_count = 2'd0;
		t1_flush = 1'b0;
		t2_flush = 1'b0;
		if (t1_head_ready)
		begin
			{commit1_valid, commit1_thread, commit1_pc, commit1_target_pc} =
				{1'b1, 1'b0, t1_head_pc, t1_head_target_pc};
			{commit1_is_branch, commit1_mispredict, commit1_arn, commit1_prn} =
				{t1_head_is_branch, t1_head_mispredict, t1_head_arn, t1_head_prn};
			t1_pop_count = 2'd1;
			t1_flush = t1_head_bad;
			if (t1_next_ready && !t1_head_bad)
			begin
				{commit2_valid, commit2_thread, commit2_pc, commit2_target_pc} =
					{1'b1, 1'b0, t1_next_pc, t1_next_target_pc};
				{commit2_is_branch, commit2_mispredict, commit2_arn, commit2_prn} =
					{t1_next_is_branch, t1_next_mispredict, t1_next_arn, t1_next_prn};
				t1_pop_count = 2'd2;
				t1_flush = t1_next_bad;
			end
			else if (t2_head_ready)	// thread 2 fills the spare slot
			begin
				{commit2_valid, commit2_thread, commit2_pc, commit2_target_pc} =
					{1'b1, 1'b1, t2_head_pc, t2_head_target_pc};
				{commit2_is_branch, commit2_mispredict, commit2_arn, commit2_prn} =
					{t2_head_is_branch, t2_head_mispredict, t2_head_arn, t2_head_prn};
				t2_pop_count = 2'd1;
				t2_flush = t2_head_bad;
			end
		end
		else if (t2_head_ready)
		begin
			{commit1_valid, commit1_thread, commit1_pc, commit1_target_pc} =
				{1'b1, 1'b1, t2_head_pc, t2_head_target_pc};
			{commit1_is_branch, commit1_mispredict, commit1_arn, commit1_prn} =
				{t2_head_is_branch, t2_head_mispredict, t2_head_arn, t2_head_prn};
			t2_pop_count = 2'd1;
			t2_flush = t2_head_bad;
			if (t2_next_ready && !t2_head_bad)
			begin
				{commit2_valid, commit2_thread, commit2_pc, commit2_target_pc} =
					{1'b1, 1'b1, t2_next_pc, t2_next_target_pc};
				{commit2_is_branch, commit2_mispredict, commit2_arn, commit2_prn} =
					{t2_next_is_branch, t2_next_mispredict, t2_next_arn, t2_next_prn};
				t2_pop_count = 2'd2;
				t2_flush = t2_next_bad;
			end
		end
	end

endmodule

`default_nettype wire

// File: rob_top.sv
// reorder buffer top level for two threads
// two thread queues, the dispatch steer and the commit selector
`timescale 1ns/1ps
`default_nettype none

module rob_top (
	input wire logic clock,
	input wire logic reset,
	input wire logic inst1_valid,
	input wire logic inst2_valid,
	input wire rob_types_pkg::thread_id_t dispatch_thread,
	input wire logic [rob_cfg_pkg::pc_bits-1:0] inst1_pc,
	input wire logic [rob_cfg_pkg::arn_bits-1:0] inst1_arn,
	input wire logic [rob_cfg_pkg::prn_bits-1:0] inst1_prn,
	input wire logic inst1_is_branch,
	input wire logic [rob_cfg_pkg::pc_bits-1:0] inst2_pc,
	input wire logic [rob_cfg_pkg::arn_bits-1:0] inst2_arn,
	input wire logic [rob_cfg_pkg::prn_bits-1:0] inst2_prn,
	input wire logic inst2_is_branch,
	input wire logic done1_valid,
	input wire rob_types_pkg::rob_tag_t done1_tag,
	input wire logic done1_mispredict,
	input wire logic [rob_cfg_pkg::pc_bits-1:0] done1_target_pc,
	input wire logic done2_valid,
	input wire rob_types_pkg::rob_tag_t done2_tag,
	input wire logic done2_mispredict,
	input wire logic [rob_cfg_pkg::pc_bits-1:0] done2_target_pc,
	output logic dispatch_accept,
	output rob_types_pkg::rob_tag_t inst1_tag,
	output rob_types_pkg::rob_tag_t inst2_tag,
	output logic t1_full,
	output logic t2_full,
	output logic commit1_valid,
	output rob_types_pkg::thread_id_t commit1_thread,
	output logic [rob_cfg_pkg::pc_bits-1:0] commit1_pc,
	output logic [rob_cfg_pkg::pc_bits-1:0] commit1_target_pc,
	output logic commit1_is_branch,
	output logic commit1_mispredict,
	output logic [rob_cfg_pkg::arn_bits-1:0] commit1_arn,
	output logic [rob_cfg_pkg::prn_bits-1:0] commit1_prn,
	output logic commit2_valid,
	output rob_types_pkg::thread_id_t commit2_thread,
	output logic [rob_cfg_pkg::pc_bits-1:0] commit2_pc,
	output logic [rob_cfg_pkg::pc_bits-1:0] commit2_target_pc,
	output logic commit2_is_branch,
	output logic commit2_mispredict,
	output logic [rob_cfg_pkg::arn_bits-1:0] commit2_arn,
	output logic [rob_cfg_pkg::prn_bits-1:0] commit2_prn
);

	// wires named after the steer and selector ports
	logic [rob_cfg_pkg::slot_bits-1:0] t1_tail_slot, t2_tail_slot;
	logic [rob_cfg_pkg::count_bits-1:0] t1_free_count, t2_free_count;
	logic [1:0] t1_alloc_count, t2_alloc_count, t1_pop_count, t2_pop_count;
	logic t1_flush, t2_flush;
	logic t1_head_ready, t1_next_ready, t2_head_ready, t2_next_ready;
	logic [rob_cfg_pkg::pc_bits-1:0] t1_head_pc, t1_next_pc, t2_head_pc, t2_next_pc;
	logic [rob_cfg_pkg::pc_bits-1:0] t1_head_target_pc, t1_next_target_pc;
	logic [rob_cfg_pkg::pc_bits-1:0] t2_head_target_pc, t2_next_target_pc;
	logic t1_head_is_branch, t1_next_is_branch, t2_head_is_branch, t2_next_is_branch;
	logic t1_head_mispredict, t1_next_mispredict, t2_head_mispredict, t2_next_mispredict;
	logic [rob_cfg_pkg::arn_bits-1:0] t1_head_arn, t1_next_arn, t2_head_arn, t2_next_arn;
	logic [rob_cfg_pkg::prn_bits-1:0] t1_head_prn, t1_next_prn, t2_head_prn, t2_next_prn;

	// thread 1 queue, shared dispatch and completion inputs by name
	rob_thread_queue #(.owner(1'b0)) rob_thread_queue_t1_i (
		.*,
		.alloc_count(t1_alloc_count), .pop_count(t1_pop_count), .flush(t1_flush),
		.tail_slot(t1_tail_slot), .free_count(t1_free_count),
		.head_ready(t1_head_ready), .head_pc(t1_head_pc),
		.head_target_pc(t1_head_target_pc), .head_is_branch(t1_head_is_branch),
		.head_mispredict(t1_head_mispredict), .head_arn(t1_head_arn),
		.head_prn(t1_head_prn), .next_ready(t1_next_ready), .next_pc(t1_next_pc),
		.next_target_pc(t1_next_target_pc), .next_is_branch(t1_next_is_branch),
		.next_mispredict(t1_next_mispredict), .next_arn(t1_next_arn),
		.next_prn(t1_next_prn)
	);

	rob_thread_queue #(.owner(1'b1)) rob_thread_queue_t2_i (
		.*,
		.alloc_count(t2_alloc_count), .pop_count(t2_pop_count), .flush(t2_flush),
		.tail_slot(t2_tail_slot), .free_count(t2_free_count),
		.head_ready(t2_head_ready), .head_pc(t2_head_pc),
		.head_target_pc(t2_head_target_pc), .head_is_branch(t2_head_is_branch),
		.head_mispredict(t2_head_mispredict), .head_arn(t2_head_arn),
		.head_prn(t2_head_prn), .next_ready(t2_next_ready), .next_pc(t2_next_pc),
		.next_target_pc(t2_next_target_pc), .next_is_branch(t2_next_is_branch),
		.next_mispredict(t2_next_mispredict), .next_arn(t2_next_arn),
		.next_prn(t2_next_prn)
	);

	rob_dispatch_steer rob_dispatch_steer_i (.*);

	rob_commit_select rob_commit_select_i (.*);

endmodule

`default_nettype wire

// File: rob_tb_cases.svh
// stimulus table for the reorder buffer testbench
// one row per cycle with dispatch, completions, expected flags and commit slots
// columns are thread count first branches | accept tag1 tag2 full1 full2 |
//          done_a mis_a done_b mis_b | commit_a commit_b
// first, done and commit columns hold instruction numbers or -1 for none

task automatic build_table();
	// tags after reset for thread 1 then thread 2
	add_row(0, 2,  0, 0, 1,  0,  1, 0, 0, -1, 0, -1, 0, -1, -1);
	add_row(1, 2,  2, 0, 1, 16, 17, 0, 0,  1, 0, -1, 0, -1, -1);	// second entry done first
	add_row(0, 0, -1, 0, 0, -1, -1, 0, 0,  0, 0, -1, 0, -1, -1);	// no commit yet
	add_row(0, 2,  4, 0, 1,  2,  3, 0, 0, -1, 0, -1, 0,  0,  1);	// both commit in order

	// mixed slot with thread 1 head only plus thread 2 head
	add_row(0, 0, -1, 0, 0, -1, -1, 0, 0,  4, 0,  2, 0, -1, -1);
	add_row(0, 2,  6, 1, 1,  4,  5, 0, 0, -1, 0, -1, 0,  4,  2);	// i6 is a branch

	// flush on a mispredicted branch at the head
	add_row(0, 2,  8, 0, 1,  6,  7, 0, 0,  5, 0,  7, 0, -1, -1);
	add_row(0, 0, -1, 0, 0, -1, -1, 0, 0,  6, 1,  8, 0,  5, -1);
	add_row(0, 2, 10, 0, 0, -1, -1, 0, 0, -1, 0, -1, 0,  6, -1);	// branch alone while blocked
	add_row(0, 2, 10, 0, 1,  5,  6, 0, 0, -1, 0, -1, 0, -1, -1);	// tag after the branch slot
	add_row(0, 0, -1, 0, 0, -1, -1, 0, 0, 10, 0, 11, 0, -1, -1);
	add_row(0, 0, -1, 0, 0, -1, -1, 0, 0, -1, 0, -1, 0, 10, 11);

	// fill thread 1 until the full flag rises
	add_row(0, 2, 12, 2, 1,  7,  8, 0, 0, -1, 0, -1, 0, -1, -1);
	add_row(0, 2, 14, 0, 1,  9, 10, 0, 0, -1, 0, -1, 0, -1, -1);
	add_row(0, 2, 16, 0, 1, 11, 12, 0, 0, -1, 0, -1, 0, -1, -1);
	add_row(0, 2, 18, 0, 1, 13, 14, 0, 0, -1, 0, -1, 0, -1, -1);
	add_row(0, 2, 20, 0, 1, 15,  0, 0, 0, -1, 0, -1, 0, -1, -1);	// tag wraps to slot 0
	add_row(0, 2, 22, 0, 1,  1,  2, 0, 0, -1, 0, -1, 0, -1, -1);
	add_row(0, 2, 24, 0, 1,  3,  4, 0, 0, -1, 0, -1, 0, -1, -1);
	add_row(0, 2, 26, 0, 1,  5,  6, 0, 0, -1, 0, -1, 0, -1, -1);
	add_row(0, 2, 28, 0, 0, -1, -1, 1, 0, -1, 0, -1, 0, -1, -1);	// refused for lack of room
	add_row(1, 2, 30, 0, 1, 18, 19, 1, 0, -1, 0, -1, 0, -1, -1);	// thread 2 still accepted

	// drain through the wrap point in order
	add_row(0, 0, -1, 0, 0, -1, -1, 1, 0, 13, 0, 12, 0, -1, -1);
	add_row(0, 0, -1, 0, 0, -1, -1, 1, 0, 20, 0, 21, 0, 12, 13);
	add_row(0, 0, -1, 0, 0, -1, -1, 0, 0, 14, 0, 15, 0, -1, -1);
	add_row(0, 0, -1, 0, 0, -1, -1, 0, 0, 16, 0, 17, 0, 14, 15);
	add_row(0, 0, -1, 0, 0, -1, -1, 0, 0, 18, 0, 19, 0, 16, 17);
	add_row(0, 0, -1, 0, 0, -1, -1, 0, 0, 22, 0, 23, 0, 18, 19);
	add_row(0, 2, 28, 0, 1,  7,  8, 0, 0, 24, 0, 25, 0, 20, 21);	// slot 15 then slot 0
	add_row(0, 0, -1, 0, 0, -1, -1, 0, 0, 26, 0, 27, 0, 22, 23);
	add_row(0, 0, -1, 0, 0, -1, -1, 0, 0, 28, 0, 29, 0, 24, 25);
	add_row(0, 0, -1, 0, 0, -1, -1, 0, 0,  3, 0, 30, 0, 26, 27);
	add_row(0, 0, -1, 0, 0, -1, -1, 0, 0, 31, 0, -1, 0, 28, 29);

	// thread 2 alone fills both slots
	add_row(0, 0, -1, 0, 0, -1, -1, 0, 0, -1, 0, -1, 0,  3, 30);
	add_row(0, 0, -1, 0, 0, -1, -1, 0, 0, -1, 0, -1, 0, 31, -1);
	add_row(0, 0, -1, 0, 0, -1, -1, 0, 0, -1, 0, -1, 0, -1, -1);
endtask

// File: rob_tb.sv
// testbench for the two-thread reorder buffer
// clock, reset, DUT, watchdog, table-driven stimulus and checks
`timescale 1ns/1ps
`default_nettype none

module rob_tb;

	// one table row per clock cycle with -1 for an unused instruction index
	typedef struct
	{
		int thread, count, first, branches;
		int accept, tag1, tag2, full1, full2;
		int done_a, mis_a, done_b, mis_b;
		int commit_a, commit_b;
	} row_t;

	logic clock;
	logic reset;
	logic inst1_valid, inst2_valid;
	rob_types_pkg::thread_id_t dispatch_thread;
	logic [rob_cfg_pkg::pc_bits-1:0] inst1_pc, inst2_pc;
	logic [rob_cfg_pkg::arn_bits-1:0] inst1_arn, inst2_arn;
	logic [rob_cfg_pkg::prn_bits-1:0] inst1_prn, inst2_prn;
	logic inst1_is_branch, inst2_is_branch;
	logic done1_valid, done2_valid, done1_mispredict, done2_mispredict;
	rob_types_pkg::rob_tag_t done1_tag, done2_tag, inst1_tag, inst2_tag;
	logic [rob_cfg_pkg::pc_bits-1:0] done1_target_pc, done2_target_pc;
	logic dispatch_accept, t1_full, t2_full;
	logic commit1_valid, commit2_valid, commit1_is_branch, commit2_is_branch;
	logic commit1_mispredict, commit2_mispredict;
	rob_types_pkg::thread_id_t commit1_thread, commit2_thread;
	logic [rob_cfg_pkg::pc_bits-1:0] commit1_pc, commit2_pc;
	logic [rob_cfg_pkg::pc_bits-1:0] commit1_target_pc, commit2_target_pc;
	logic [rob_cfg_pkg::arn_bits-1:0] commit1_arn, commit2_arn;
	logic [rob_cfg_pkg::prn_bits-1:0] commit1_prn, commit2_prn;

	// random payload per instruction number
	logic [rob_cfg_pkg::pc_bits-1:0] pc_of [64];
	logic [rob_cfg_pkg::pc_bits-1:0] target_of [64];
	logic [rob_cfg_pkg::arn_bits-1:0] arn_of [64];
	logic [rob_cfg_pkg::prn_bits-1:0] prn_of [64];
	int thread_of [64];		// expected thread, tag and flags of each instruction
	int branch_of [64];
	int tag_of [64];
	int mis_of [64];
	row_t rows [$];
	int error_count;
	logic table_ready;

	rob_top rob_top_i (.*);

	always #10 clock = ~clock;

	task automatic add_row(input int thread, count, first, branches, accept, tag1, tag2,
		full1, full2, done_a, mis_a, done_b, mis_b, commit_a, commit_b);
		row_t r;
		int j;
		r = '{thread, count, first, branches, accept, tag1, tag2, full1, full2,
			done_a, mis_a, done_b, mis_b, commit_a, commit_b};
		if (accept != 0)
			for (j = 0; j < count; j++)
			begin
				thread_of[first + j] = thread;
				branch_of[first + j] = (branches >> j) & 1;
				tag_of[first + j] = (j == 0) ? tag1 : tag2;
			end
		if (done_a >= 0)
			mis_of[done_a] = mis_a;
		if (done_b >= 0)
			mis_of[done_b] = mis_b;
		rows.push_back(r);
	endtask

	`include "rob_tb_cases.svh"

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		error_count++;
		$display("ERROR %0t %s expected %0h actual %0h", $time, name, expected, actual);
	endtask

	task automatic check_commit(input int slot, input int n, input logic valid,
		input logic thread, input logic [63:0] pc, input logic [63:0] target,
		input logic branch, input logic mis, input logic [4:0] arn, input logic [5:0] prn);
		string p;
		p = $sformatf("commit%0d_", slot);
		if (valid !== (n >= 0))
			report_mismatch({p, "valid"}, 64'(n >= 0), 64'(valid));
		if (n >= 0)
		begin
			if (thread !== 1'(thread_of[n]))
				report_mismatch({p, "thread"}, thread_of[n], thread);
			if (pc !== pc_of[n])
				report_mismatch({p, "pc"}, pc_of[n], pc);
			if (target !== target_of[n])
				report_mismatch({p, "target_pc"}, target_of[n], target);
			if (branch !== 1'(branch_of[n]))
				report_mismatch({p, "is_branch"}, branch_of[n], branch);
			if (mis !== 1'(mis_of[n]))
				report_mismatch({p, "mispredict"}, mis_of[n], mis);
			if (arn !== arn_of[n])
				report_mismatch({p, "arn"}, 64'(arn_of[n]), 64'(arn));
			if (prn !== prn_of[n])
				report_mismatch({p, "prn"}, 64'(prn_of[n]), 64'(prn));
		end
	endtask

	task automatic drive_row(input row_t r);
		int f;
		int a;
		int b;
		f = (r.first < 0) ? 0 : r.first;
		a = (r.done_a < 0) ? 0 : r.done_a;
		b = (r.done_b < 0) ? 0 : r.done_b;
		inst1_valid = (r.count >= 1);
		inst2_valid = (r.count == 2);
		dispatch_thread = 1'(r.thread);
		{inst1_pc, inst1_arn, inst1_prn} = {pc_of[f], arn_of[f], prn_of[f]};
		{inst2_pc, inst2_arn, inst2_prn} = {pc_of[f + 1], arn_of[f + 1], prn_of[f + 1]};
		inst1_is_branch = r.branches[0];
		inst2_is_branch = r.branches[1];
		done1_valid = (r.done_a >= 0);
		done1_tag.flat = 5'(tag_of[a]);
		done1_mispredict = r.mis_a[0];
		done1_target_pc = target_of[a];
		done2_valid = (r.done_b >= 0);
		done2_tag.flat = 5'(tag_of[b]);
		done2_mispredict = r.mis_b[0];
		done2_target_pc = target_of[b];
	endtask

	task automatic check_row(input row_t r);
		if (r.count > 0 && dispatch_accept !== r.accept[0])
			report_mismatch("dispatch_accept", 64'(r.accept), 64'(dispatch_accept));
		if (r.accept != 0 && inst1_tag.flat !== 5'(r.tag1))
			report_mismatch("inst1_tag", 64'(r.tag1), 64'(inst1_tag.flat));
		if (r.accept != 0 && r.count == 2 && inst2_tag.flat !== 5'(r.tag2))
			report_mismatch("inst2_tag", 64'(r.tag2), 64'(inst2_tag.flat));
		if (t1_full !== r.full1[0])
			report_mismatch("t1_full", 64'(r.full1), 64'(t1_full));
		if (t2_full !== r.full2[0])
			report_mismatch("t2_full", 64'(r.full2), 64'(t2_full));
		check_commit(1, r.commit_a, commit1_valid, commit1_thread, commit1_pc,
			commit1_target_pc, commit1_is_branch, commit1_mispredict, commit1_arn, commit1_prn);
		check_commit(2, r.commit_b, commit2_valid, commit2_thread, commit2_pc,
			commit2_target_pc, commit2_is_branch, commit2_mispredict, commit2_arn, commit2_prn);
	endtask

	initial
	begin
		row_t idle;
		int n;
		int k;
		clock = 1'b0;
		reset = 1'b1;
		table_ready = 1'b0;
		error_count = 0;
		void'($urandom(20393));
		for (n = 0; n < 64; n++)
		begin
			pc_of[n] = {$urandom, $urandom};
			target_of[n] = {$urandom, $urandom};
			arn_of[n] = rob_cfg_pkg::arn_bits'($urandom);
			prn_of[n] = rob_cfg_pkg::prn_bits'($urandom);
		end
		idle = '{0, 0, -1, 0, 0, -1, -1, 0, 0, -1, 0, -1, 0, -1, -1};
		drive_row(idle);	// quiet inputs through reset
		build_table();
		table_ready = 1'b1;
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		for (k = 0; k < rows.size(); k++)
		begin
			drive_row(rows[k]);
			#9;				// just before the next rising edge
			check_row(rows[k]);
			@(negedge clock);
		end
		$display("%0d errors over %0d rows", error_count, rows.size());
		if (error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// watchdog sized from the table length
	initial
	begin
		wait (table_ready === 1'b1);
		#((rows.size() + 10) * 20);
		$display("watchdog timeout, the stimulus loop did not finish in time");
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
rob_cfg_pkg.sv
rob_types_pkg.sv
rob_thread_queue.sv
rob_dispatch_steer.sv
rob_commit_select.sv
rob_top.sv
rob_tb.sv

// File: Makefile
# Verilator build and run of the reorder buffer testbench

LOG = sim.log

all: run

build:
	verilator --binary --timing -Wno-fatal -f files.f --top-module rob_tb -o rob_tb_sim

run: build
	./obj_dir/rob_tb_sim | tee $(LOG)
	grep -q "all tests passed" $(LOG)

lint:
	verilator --lint-only --timing -f files.f --top-module rob_top

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean
